/* dv/cfg_interface_sva.sv */
// ####################
// cfg interface assertions
// bus idle levels and done behaviour
// ####################
`timescale 1ns/1ps

module cfg_interface_sva (
	input logic i_clk,
	input logic i_rstn,
	input logic i_start,
	input logic i_busy,
	input logic i_done,
	input logic i_scl_drv,
	input logic i_sda_drv
);

	logic frame_seen;    // set once the master has begun its first frame

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			frame_seen <= 1'b0;
		end else if (i_busy) begin
			frame_seen <= 1'b1;
		end
	end

	a_idle_after_reset: assert property (@(posedge i_clk) disable iff (!i_rstn)
		!frame_seen |-> (i_scl_drv && i_sda_drv))
		else $error("SCCB lines moved before the first frame");

	a_done_bus_free: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_done |-> (i_scl_drv && i_sda_drv))
		else $error("SCCB lines driven low while done is high");

	// done only clears on an accepted start
	a_done_falls_on_start: assert property (@(posedge i_clk) disable iff (!i_rstn)
		$fell(i_done) |-> $past(i_start))
		else $error("done fell without a start in the previous cycle");

endmodule

bind cfg_interface cfg_interface_sva u_cfg_interface_sva (
	.i_clk     (i_clk),
	.i_rstn    (i_rstn),
	.i_start   (i_start),
	.i_busy    (busy),
	.i_done    (o_done),
	.i_scl_drv (o_scl),
	.i_sda_drv (o_sda)
);

/* dv/cfg_interface_tb.sv */
// ####################
// cfg interface testbench
// runs the command table, watches the SCCB bus
// checks frames, gaps, restart and clock stretch
// ####################
`timescale 1ns/1ps
`include "cfg_defs.svh"

module cfg_interface_tb;

	localparam int DELAY          = 400;
	localparam int QUARTER        = 4;
	localparam int STRETCH_CYCLES = 20;
	localparam int FRAMES_PER_RUN = 5;
	// start, 27 bits, stop and gap, four quarters each
	localparam int FRAME_CYCLES   = 30 * 4 * QUARTER;
	localparam int RUN_CYCLES     = FRAMES_PER_RUN * (FRAME_CYCLES + 16) + DELAY;
	// four table runs and the idle watch, with plenty of margin
	localparam int TIMEOUT        = 4 * (4 * RUN_CYCLES + 200);

	logic clk;
	logic rstn;
	logic start;
	logic stretch;     // testbench holding SCL low
	logic done;
	logic scl_out;
	logic sda_out;
	logic scl_line;

	assign scl_line = scl_out & ~stretch;    // wired-AND of the open-drain SCL

	cfg_interface #(
		.DELAY_CYCLES   (DELAY),
		.QUARTER_CYCLES (QUARTER)
	) i_cfg_interface (
		.i_clk   (clk),
		.i_rstn  (rstn),
		.i_start (start),
		.i_scl   (scl_line),
		.o_done  (done),
		.o_scl   (scl_out),
		.o_sda   (sda_out)
	);

	cfg_pkg::rom_word_t exp_writes[$];
	logic [7:0]         mon_id[$];
	logic [7:0]         mon_reg[$];
	logic [7:0]         mon_data[$];
	int                 mon_start[$];
	int                 mon_stop[$];
	int                 mon_bits[$];
	int                 cycle;
	int                 start_count;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "run stopped at the first failure");
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT) begin
			fail_run($sformatf("timeout: no result after %0d cycles", TIMEOUT));
		end
	end

	// bus monitor, sampled mid cycle
	logic        prev_scl;
	logic        prev_sda;
	logic        in_frame;
	logic [23:0] data_bits;
	int          bit_idx;
	int          frame_start;

	always @(negedge clk) begin
		if (!rstn) begin
			prev_scl = 1'b1;
			prev_sda = 1'b1;
			in_frame = 1'b0;
			start_count <= 0;
		end else begin
			if (prev_scl && scl_line && prev_sda && !sda_out) begin
				in_frame    = 1'b1;    // start condition
				bit_idx     = 0;
				frame_start = cycle;
				start_count <= start_count + 1;
			end else if (prev_scl && scl_line && !prev_sda && sda_out) begin
				if (in_frame) begin    // stop condition
					mon_id.push_back(data_bits[23:16]);
					mon_reg.push_back(data_bits[15:8]);
					mon_data.push_back(data_bits[7:0]);
					mon_start.push_back(frame_start);
					mon_stop.push_back(cycle);
					mon_bits.push_back(bit_idx);
				end
				in_frame = 1'b0;
			end else if (!prev_scl && scl_line && in_frame) begin
				// every ninth bit is the don't care bit
				if (bit_idx < 27 && bit_idx % 9 != 8) begin
					data_bits = {data_bits[22:0], sda_out};
				end
				bit_idx = bit_idx + 1;
			end
			prev_scl = scl_line;
			prev_sda = sda_out;
		end
	end

	function automatic cfg_pkg::rom_word_t table_word(input int idx);
		case (idx)
			0:       return 16'h1280;
			1:       return 16'hFFF0;
			2:       return 16'h1101;
			3:       return 16'h0C04;
			4:       return 16'h40D0;
			5:       return 16'h3A04;
			default: return 16'hFFFF;
		endcase
	endfunction

	task automatic build_expected();
		cfg_pkg::rom_word_t w;
		for (int i = 0; i < 8; i++) begin
			w = table_word(i);
			if (w == `CFG_CMD_END) break;
			if (w != `CFG_CMD_DELAY) exp_writes.push_back(w);
		end
	endtask

	task automatic check_byte(input string test, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch in %s: expected 0x%02h, actual 0x%02h", test, exp, act));
		end
	endtask

	task automatic check_flag(input string test, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch in %s: expected %b, actual %b", test, exp, act));
		end
	endtask

	// register and data bytes of a frame rebuilt into a table word
	task automatic check_word(input string test, input cfg_pkg::rom_word_t exp,
		input logic [7:0] reg_b, input logic [7:0] data_b);
		cfg_pkg::rom_word_t act;
		act = {reg_b, data_b};
		if (act !== exp) begin
			fail_run($sformatf("mismatch in %s: expected 0x%04h, actual 0x%04h", test, exp, act));
		end
	endtask

	task automatic check_run_frames(input string test, input int first);
		int n;
		n = exp_writes.size();
		if (mon_id.size() != first + n) begin
			fail_run($sformatf("mismatch in %s: expected %0d frames, actual %0d",
				test, n, mon_id.size() - first));
		end
		for (int i = 0; i < n; i++) begin
			// 27 bit clocks plus the clock leading into the stop
			if (mon_bits[first + i] != 28) begin
				fail_run($sformatf("mismatch in %s: expected 28 SCL pulses in frame %0d, actual %0d",
					test, i, mon_bits[first + i]));
			end
			check_byte(test, 8'h42, mon_id[first + i]);    // 0x21 with write bit
			check_word(test, exp_writes[i], mon_reg[first + i], mon_data[first + i]);
		end
	endtask

	task automatic wait_done();
		@(negedge clk);
		while (!done) @(negedge clk);
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic auto_run();
		@(negedge clk);
		check_flag("auto_run", 1'b0, done);    // low out of reset
		wait_done();
		check_run_frames("auto_run", 0);
	endtask

	task automatic delay_gap();
		int gap;
		for (int i = 1; i < exp_writes.size(); i++) begin
			gap = mon_start[i] - mon_stop[i - 1];
			if (i == 1 && gap < DELAY) begin
				fail_run($sformatf("delay_gap: delay gap only %0d cycles", gap));
			end else if (i != 1 && gap >= DELAY) begin
				fail_run($sformatf("delay_gap: gap before frame %0d is %0d cycles", i, gap));
			end
		end
	endtask

	task automatic restart();
		int base;
		base = mon_id.size();
		pulse_start();
		@(negedge clk);
		check_flag("restart", 1'b0, done);    // cleared the cycle after start
		wait_done();
		check_run_frames("restart", base);
	endtask

	task automatic start_ignored_busy();
		int base;
		base = mon_id.size();
		pulse_start();
		repeat (3) begin
			repeat (300) @(negedge clk);
			check_flag("start_ignored_busy", 1'b0, done);
			pulse_start();
		end
		wait_done();
		check_run_frames("start_ignored_busy", base);
	endtask

	task automatic clock_stretch();
		int base;
		int starts;
		int plain;
		int longer;
		base   = mon_id.size();
		starts = start_count;
		pulse_start();
		@(negedge clk);
		while (start_count < starts + 2) @(negedge clk);
		repeat (10 * 4 * QUARTER) @(negedge clk);    // about ten bits in
		while (scl_out) @(negedge clk);
		@(posedge clk);
		stretch <= 1'b1;
		@(negedge clk);
		while (!scl_out) @(negedge clk);
		// the master's own high quarter runs inside the hold
		repeat (QUARTER + STRETCH_CYCLES) @(posedge clk);
		stretch <= 1'b0;
		wait_done();
		check_run_frames("clock_stretch", base);
		plain  = mon_stop[base] - mon_start[base];
		longer = mon_stop[base + 1] - mon_start[base + 1];
		if (longer < plain + STRETCH_CYCLES) begin
			fail_run($sformatf("clock_stretch: frame grew only from %0d to %0d cycles",
				plain, longer));
		end
	endtask

	task automatic bus_idle();
		int starts;
		starts = start_count;
		repeat (200) begin
			@(negedge clk);
			check_flag("bus_idle", 1'b1, scl_line);
			check_flag("bus_idle", 1'b1, sda_out);
		end
		@(posedge clk);
		if (start_count != starts) begin
			fail_run("bus_idle: start condition seen after the table ended");
		end
		check_flag("bus_idle", 1'b1, done);
	endtask

	initial begin
		rstn    <= 1'b0;
		start   <= 1'b0;
		stretch <= 1'b0;
		build_expected();
		repeat (10) @(posedge clk);
		rstn <= 1'b1;
		auto_run();
		delay_gap();
		restart();
		start_ignored_busy();
		clock_stretch();
		bus_idle();
		$display("All tests passed!");
		$finish;
	end

endmodule

/* hdl/cfg_defs.svh */
// ###################
// cfg defs
// slave address, command codes, table depth
// and default timing for the sensor setup
// ###################
`ifndef CFG_DEFS_SVH
`define CFG_DEFS_SVH

`define CFG_SLAVE_ADDR     7'h21    // sensor write address before shift
`define CFG_CMD_DELAY      16'hFFF0
`define CFG_CMD_END        16'hFFFF
`define CFG_ROM_AW         8

// 1 ms at 125 MHz
`define CFG_DELAY_CYCLES   125000

// quarter of a 100 kHz SCL period at 125 MHz
`define CFG_QUARTER_CYCLES 313

`endif

/* hdl/cfg_delay_timer.sv */
// ###################
// cfg delay timer
// loadable down-counter, flags expiry at zero
// ###################
`timescale 1ns/1ps

module cfg_delay_timer #(
	parameter int WIDTH = 8
) (
	input  logic             i_clk,
	input  logic             i_rstn,
	input  logic             i_load,
	input  logic [WIDTH-1:0] i_count,
	output logic             o_expired
);

	logic [WIDTH-1:0] count;

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			count <= '0;
		end else if (i_load) begin
			count <= i_count;
		end else if (count != '0) begin
			count <= count - 1'b1;    // stops at zero
		end
	end

	assign o_expired = (count == '0);

endmodule

/* hdl/cfg_interface.sv */
// ###################
// cfg interface
// sensor setup top, table rom into sequencer
// into the SCCB master
// ###################
`timescale 1ns/1ps
`include "cfg_defs.svh"

module cfg_interface #(
	parameter int DELAY_CYCLES   = `CFG_DELAY_CYCLES,
	parameter int QUARTER_CYCLES = `CFG_QUARTER_CYCLES
) (
	input  logic i_clk,
	input  logic i_rstn,
	input  logic i_start,
	input  logic i_scl,      // resolved SCL, for stretch detection
	output logic o_done,
	output logic o_scl,
	output logic o_sda
);

	logic [`CFG_ROM_AW-1:0] rom_addr;
	cfg_pkg::rom_word_t     rom_data;
	logic                   wr_stb;
	logic [7:0]             reg_addr;
	logic [7:0]             wdata;
	logic                   busy;

	cfg_rom u_rom (
		.i_clk  (i_clk),
		.i_addr (rom_addr),
		.o_data (rom_data)
	);

	cfg_sequencer #(
		.DELAY_CYCLES(DELAY_CYCLES)
	) u_sequencer (
		.i_clk      (i_clk),
		.i_rstn     (i_rstn),
		.i_start    (i_start),
		.i_rom_data (rom_data),
		.i_busy     (busy),
		.o_rom_addr (rom_addr),
		.o_wr_stb   (wr_stb),
		.o_reg_addr (reg_addr),
		.o_wdata    (wdata),
		.o_done     (o_done)
	);

	sccb_master #(
		.QUARTER_CYCLES(QUARTER_CYCLES)
	) u_sccb_master (
		.i_clk      (i_clk),
		.i_rstn     (i_rstn),
		.i_wr_stb   (wr_stb),
		.i_reg_addr (reg_addr),
		.i_wdata    (wdata),
		.i_scl      (i_scl),
		.o_busy     (busy),
		.o_scl      (o_scl),
		.o_sda      (o_sda)
	);

endmodule

/* hdl/cfg_pkg.sv */
// ###################
// cfg pkg
// shared types of the sensor setup logic
// ###################
package cfg_pkg;

	// one table entry, register address in the upper byte
	typedef struct packed {
		logic [7:0] reg_addr;
		logic [7:0] wdata;
	} rom_word_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_WAIT,
		SEQ_DONE
	} seq_state_t;

	typedef enum logic [2:0] {
		SCCB_IDLE,
		SCCB_START,
		SCCB_BIT,
		SCCB_STOP,
		SCCB_GAP
	} sccb_state_t;

endpackage

/* hdl/cfg_rom.sv */
// ###################
// cfg rom
// fixed command table for the camera sensor
// one cycle read latency
// ###################
`timescale 1ns/1ps
`include "cfg_defs.svh"

module cfg_rom (
	input  logic                   i_clk,
	input  logic [`CFG_ROM_AW-1:0] i_addr,
	output cfg_pkg::rom_word_t     o_data
);

	// registered lookup, anything past the table reads as end
	always_ff @(posedge i_clk) begin
		case (i_addr)
			`CFG_ROM_AW'd0: o_data <= 16'h1280;         // COM7 soft reset
			`CFG_ROM_AW'd1: o_data <= `CFG_CMD_DELAY;   // settle after reset
			`CFG_ROM_AW'd2: o_data <= 16'h1101;         // clock prescaler
			`CFG_ROM_AW'd3: o_data <= 16'h0C04;         // COM3
			`CFG_ROM_AW'd4: o_data <= 16'h40D0;         // COM15 output range
			`CFG_ROM_AW'd5: o_data <= 16'h3A04;         // TSLB
			default:        o_data <= `CFG_CMD_END;
		endcase
	end

endmodule

/* hdl/cfg_sequencer.sv */
// ###################
// cfg sequencer
// walks the command table, issues writes
// and runs delays
// ###################
`timescale 1ns/1ps
`include "cfg_defs.svh"

module cfg_sequencer #(
	parameter int DELAY_CYCLES = `CFG_DELAY_CYCLES
) (
	input  logic                   i_clk,
	input  logic                   i_rstn,
	input  logic                   i_start,
	input  cfg_pkg::rom_word_t     i_rom_data,
	input  logic                   i_busy,
	output logic [`CFG_ROM_AW-1:0] o_rom_addr,
	output logic                   o_wr_stb,
	output logic [7:0]             o_reg_addr,
	output logic [7:0]             o_wdata,
	output logic                   o_done
);

	localparam int TW = $clog2(DELAY_CYCLES + 1);

	cfg_pkg::seq_state_t state;
	logic settle;           // first cycle of FETCH or WAIT
	logic timer_load;
	logic timer_expired;
	logic decode;

	cfg_delay_timer #(
		.WIDTH(TW)
	) u_delay_timer (
		.i_clk     (i_clk),
		.i_rstn    (i_rstn),
		.i_load    (timer_load),
		.i_count   (TW'(DELAY_CYCLES)),
		.o_expired (timer_expired)
	);

	// rom word is valid in the second cycle of FETCH
	assign decode = (state == cfg_pkg::SEQ_FETCH) && !settle;

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			state      <= cfg_pkg::SEQ_FETCH;    // table runs once out of reset
			settle     <= 1'b1;
			o_rom_addr <= '0;
			o_wr_stb   <= 1'b0;
			timer_load <= 1'b0;
			o_done     <= 1'b0;
		end else begin
			o_wr_stb   <= 1'b0;
			timer_load <= 1'b0;
			settle     <= 1'b0;
			case (state)
				cfg_pkg::SEQ_IDLE: begin
					if (i_start) begin
						o_done     <= 1'b0;
						o_rom_addr <= '0;
						settle     <= 1'b1;
						state      <= cfg_pkg::SEQ_FETCH;
					end
				end
				cfg_pkg::SEQ_FETCH: begin
					if (decode) begin
						if (i_rom_data == `CFG_CMD_END) begin
							state <= cfg_pkg::SEQ_DONE;
						end else begin
							o_rom_addr <= o_rom_addr + 1'b1;
							settle     <= 1'b1;
							state      <= cfg_pkg::SEQ_WAIT;
							if (i_rom_data == `CFG_CMD_DELAY) begin
								timer_load <= 1'b1;
							end else begin
								o_wr_stb <= 1'b1;
							end
						end
					end
				end
				cfg_pkg::SEQ_WAIT: begin
					// busy and timer are not valid until after the settle cycle
					if (!settle && !i_busy && timer_expired) begin
						settle <= 1'b1;
						state  <= cfg_pkg::SEQ_FETCH;
					end
				end
				default: begin    // SEQ_DONE
					o_done <= 1'b1;
					state  <= cfg_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (decode) begin
			o_reg_addr <= i_rom_data.reg_addr;
			o_wdata    <= i_rom_data.wdata;
		end
	end

endmodule

/* hdl/sccb_master.sv */
// ###################
// sccb master
// write-only three-phase SCCB transmitter
// four quarters per bit, waits on a stretched SCL
// ###################
`timescale 1ns/1ps
`include "cfg_defs.svh"

module sccb_master #(
	parameter int QUARTER_CYCLES = `CFG_QUARTER_CYCLES
) (
	input  logic       i_clk,
	input  logic       i_rstn,
	input  logic       i_wr_stb,
	input  logic [7:0] i_reg_addr,
	input  logic [7:0] i_wdata,
	input  logic       i_scl,
	output logic       o_busy,
	output logic       o_scl,
	output logic       o_sda
);

	localparam int TW = $clog2(QUARTER_CYCLES + 1);
	localparam logic [4:0] LAST_BIT = 5'd26;

	cfg_pkg::sccb_state_t state;
	logic [26:0] frame;       // shifted out MSB first
	logic [4:0]  bit_cnt;
	logic [1:0]  quarter;
	logic        q_expired;
	logic        stretched;
	logic        launch;
	logic        step;

	assign launch = (state == cfg_pkg::SCCB_IDLE) && i_wr_stb;

	// line released by us but still held low by the slave
	assign stretched = o_scl && !i_scl;
	assign step = (state != cfg_pkg::SCCB_IDLE) && q_expired && !stretched;

	// a quarter lasts QUARTER_CYCLES clocks
	cfg_delay_timer #(
		.WIDTH(TW)
	) u_quarter_timer (
		.i_clk     (i_clk),
		.i_rstn    (i_rstn),
		.i_load    (launch || step),
		.i_count   (TW'(QUARTER_CYCLES - 1)),
		.o_expired (q_expired)
	);

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			state   <= cfg_pkg::SCCB_IDLE;
			quarter <= 2'd0;
			bit_cnt <= 5'd0;
		end else if (launch) begin
			state   <= cfg_pkg::SCCB_START;
			quarter <= 2'd0;
			bit_cnt <= 5'd0;
		end else if (step) begin
			quarter <= quarter + 2'd1;    // wraps into the next phase
			if (quarter == 2'd3) begin
				case (state)
					cfg_pkg::SCCB_START: state <= cfg_pkg::SCCB_BIT;
					cfg_pkg::SCCB_BIT: begin
						if (bit_cnt == LAST_BIT) begin
							state <= cfg_pkg::SCCB_STOP;
						end else begin
							bit_cnt <= bit_cnt + 5'd1;
						end
					end
					cfg_pkg::SCCB_STOP: state <= cfg_pkg::SCCB_GAP;
					cfg_pkg::SCCB_GAP:  state <= cfg_pkg::SCCB_IDLE;
					default:            state <= cfg_pkg::SCCB_IDLE;
				endcase
			end
		end
	end

	// ID byte, register byte, data byte, each followed by a released bit
	always_ff @(posedge i_clk) begin
		if (launch) begin
			frame <= {`CFG_SLAVE_ADDR, 1'b0, 1'b1, i_reg_addr, 1'b1, i_wdata, 1'b1};
		end else if (step && state == cfg_pkg::SCCB_BIT && quarter == 2'd3) begin
			frame <= {frame[25:0], 1'b1};
		end
	end

	always_comb begin
		o_scl = 1'b1;
		o_sda = 1'b1;
		case (state)
			cfg_pkg::SCCB_START: begin
				o_sda = (quarter == 2'd0);    // falls while SCL high
				o_scl = (quarter != 2'd3);
			end
			cfg_pkg::SCCB_BIT: begin
				o_sda = frame[26];             // only changes while SCL low
				o_scl = (quarter == 2'd1) || (quarter == 2'd2);
			end
			cfg_pkg::SCCB_STOP: begin
				o_sda = (quarter >= 2'd2);    // rises while SCL high
				o_scl = (quarter != 2'd0);
			end
			default: begin
				o_sda = 1'b1;
				o_scl = 1'b1;
			end
		endcase
	end

	// high from the cycle after the strobe until the gap ends
	assign o_busy = (state != cfg_pkg::SCCB_IDLE);

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module cfg_interface_tb -o sim_cfg_interface

status=0
./obj_dir/sim_cfg_interface > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failures found" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"

/* sources.f */
+incdir+hdl
hdl/cfg_pkg.sv
hdl/cfg_rom.sv
hdl/cfg_delay_timer.sv
hdl/sccb_master.sv
hdl/cfg_sequencer.sv
hdl/cfg_interface.sv
dv/cfg_interface_sva.sv
dv/cfg_interface_tb.sv
